/* rtl/boot_fetch.sv */
////////////////////
// block fetcher
// walks the flash block one word at a time through the read engine and
// pushes each word, tagged with its index, into the word FIFO
////////////////////

`timescale 1ns/10ps

module boot_fetch import flash_boot_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  word_cnt_t  boot_base,
  input  word_cnt_t  boot_words,
  input  logic       fifo_full,
  output logic       push,
  output boot_word_t push_word,
  output logic       busy,
  input  logic       wr_done,
  output fl_pins_t   fl_pins,
  input  fl_data_t   fl_dat_r
);

  fetch_state_t state;
  word_cnt_t    base_q;
  word_cnt_t    cnt_q;
  word_cnt_t    idx_q;    // next word to read
  logic         rd_req;
  word_cnt_t    rd_word;
  logic         rd_done;
  word_t        rd_data;

  // one read in flight at most, so a free entry always waits for it
  assign rd_req  = (state == FE_ISSUE) && !fifo_full;
  assign rd_word = base_q + idx_q;

  assign push      = (state == FE_WAIT) && rd_done;
  assign push_word = '{idx: idx_q, data: rd_data};
  assign busy      = (state != FE_IDLE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= FE_IDLE;
      base_q <= '0;
      cnt_q  <= '0;
      idx_q  <= '0;
    end else begin
      case (state)
        FE_IDLE: if (start) begin
          base_q <= boot_base;
          cnt_q  <= boot_words;
          idx_q  <= '0;
          state  <= FE_ISSUE;
        end
        FE_ISSUE: if (rd_req) state <= FE_WAIT;
        FE_WAIT: if (rd_done) begin
          idx_q <= idx_q + 1'b1;
          state <= (idx_q == cnt_q - word_cnt_t'(1)) ? FE_DONE : FE_ISSUE;
        end
        default: if (wr_done) state <= FE_IDLE;  // wait for the writer to drain
      endcase
    end
  end

  flash_read_ctrl rd_ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .rd_req   (rd_req),
    .rd_word  (rd_word),
    .rd_done  (rd_done),
    .rd_data  (rd_data),
    .fl_pins  (fl_pins),
    .fl_dat_r (fl_dat_r)
  );

endmodule

/* rtl/flash_boot_pkg.sv */
////////////////////
// shared constants, types and state encodings for the flash boot copy engine
// import with a wildcard in the module header of each RTL file
////////////////////

package flash_boot_pkg;

  localparam int FL_AW      = 22;  // flash byte address
  localparam int FL_DW      = 8;   // flash data bus
  localparam int WORD_W     = 32;
  localparam int FL_DLY     = 4;   // cycles per byte, 160 ns at 25 MHz
  localparam int FIFO_DEPTH = 4;
  localparam int CNT_W      = 12;  // word counts and indexes
  localparam int MEM_AW     = 16;  // memory word address

  typedef logic [FL_AW-1:0]                fl_addr_t;
  typedef logic [FL_DW-1:0]                fl_data_t;
  typedef logic [WORD_W-1:0]               word_t;
  typedef logic [CNT_W-1:0]                word_cnt_t;
  typedef logic [MEM_AW-1:0]               mem_addr_t;
  typedef logic [$clog2(FL_DLY)-1:0]       dly_cnt_t;   // byte hold timer
  typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH):0]     fifo_cnt_t;  // one extra bit for full

  // flash control outputs, all strobes active low
  typedef struct packed {
    fl_addr_t adr;
    logic     ce_n;
    logic     oe_n;
    logic     rst_n;
  } fl_pins_t;

  // one buffered word tagged with its place in the block
  typedef struct packed {
    word_cnt_t idx;
    word_t     data;
  } boot_word_t;

  typedef enum logic [2:0] {RD_IDLE, RD_BYTE0, RD_BYTE1, RD_BYTE2, RD_BYTE3} rd_state_t;
  typedef enum logic [1:0] {FE_IDLE, FE_ISSUE, FE_WAIT, FE_DONE} fetch_state_t;

endpackage

/* rtl/flash_boot_top.sv */
////////////////////
// boot copy engine top level
// a start pulse copies boot_words words from flash word boot_base
// into memory from dest_base, done pulses once when the copy is complete
////////////////////

`timescale 1ns/10ps

module flash_boot_top import flash_boot_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  word_cnt_t boot_base,
  input  word_cnt_t boot_words,
  input  mem_addr_t dest_base,
  output fl_pins_t  fl_pins,
  input  fl_data_t  fl_dat_r,
  input  logic      mem_ready,
  output logic      mem_we,
  output mem_addr_t mem_adr,
  output word_t     mem_dat,
  output logic      busy,
  output logic      done
);

  logic       push;
  boot_word_t push_word;
  logic       pop;
  boot_word_t head;
  logic       empty;
  logic       full;
  logic       wr_done;

  assign done = wr_done;

  boot_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .boot_base  (boot_base),
    .boot_words (boot_words),
    .fifo_full  (full),
    .push       (push),
    .push_word  (push_word),
    .busy       (busy),
    .wr_done    (wr_done),
    .fl_pins    (fl_pins),
    .fl_dat_r   (fl_dat_r)
  );

  word_fifo fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  mem_writer writer_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .dest_base  (dest_base),
    .boot_words (boot_words),
    .empty      (empty),
    .head       (head),
    .mem_ready  (mem_ready),
    .pop        (pop),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat    (mem_dat),
    .wr_done    (wr_done)
  );

endmodule

/* rtl/flash_read_ctrl.sv */
////////////////////
// byte-wide NOR flash read engine
// keeps the part in read mode and fetches one 32-bit word per rd_req pulse,
// four bytes big-endian, each address held FL_DLY cycles before sampling
// rd_done pulses 4*FL_DLY+1 cycles after rd_req
////////////////////

`timescale 1ns/10ps

module flash_read_ctrl import flash_boot_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      rd_req,
  input  word_cnt_t rd_word,
  output logic      rd_done,
  output word_t     rd_data,
  output fl_pins_t  fl_pins,
  input  fl_data_t  fl_dat_r
);

  rd_state_t state;
  dly_cnt_t  timer;
  fl_addr_t  fl_adr;
  logic      ce_n;
  logic      oe_n;
  logic      fl_rst_n;
  logic      sample;  // current byte ready on the bus

  ////////////////////
  // read mode strobes
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ce_n     <= 1'b1;
      oe_n     <= 1'b1;
      fl_rst_n <= 1'b0;  // hold part in reset
    end else begin
      ce_n     <= 1'b0;
      oe_n     <= 1'b0;
      fl_rst_n <= 1'b1;
    end
  end

  ////////////////////
  // byte sequencer
  ////////////////////

  assign sample = (state != RD_IDLE) && (timer == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= RD_IDLE;
      timer   <= '0;
      fl_adr  <= '0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      if (state == RD_IDLE) begin
        if (rd_req) begin
          fl_adr <= fl_addr_t'({rd_word, 2'b00});  // byte 0 of the word
          timer  <= dly_cnt_t'(FL_DLY - 1);
          state  <= RD_BYTE0;
        end
      end else if (!sample) begin
        timer <= timer - 1'b1;
      end else begin
        timer <= dly_cnt_t'(FL_DLY - 1);
        case (state)
          RD_BYTE0: state <= RD_BYTE1;
          RD_BYTE1: state <= RD_BYTE2;
          RD_BYTE2: state <= RD_BYTE3;
          default: begin
            state   <= RD_IDLE;
            rd_done <= 1'b1;  // last byte captured this edge
          end
        endcase
        if (state != RD_BYTE3) begin
          fl_adr[1:0] <= fl_adr[1:0] + 2'd1;  // next byte
        end
      end
    end
  end

  // first byte ends up in the top lane after four shifts
  always_ff @(posedge clk) begin
    if (sample) begin
      rd_data <= {rd_data[WORD_W-FL_DW-1:0], fl_dat_r};
    end
  end

  assign fl_pins = '{adr: fl_adr, ce_n: ce_n, oe_n: oe_n, rst_n: fl_rst_n};

endmodule

/* rtl/mem_writer.sv */
////////////////////
// drains the word FIFO into the on-chip memory port
// writes whenever a word is waiting and mem_ready is high,
// wr_done pulses the cycle after the block's last index is written
////////////////////

`timescale 1ns/10ps

module mem_writer import flash_boot_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  mem_addr_t  dest_base,
  input  word_cnt_t  boot_words,
  input  logic       empty,
  input  boot_word_t head,
  input  logic       mem_ready,
  output logic       pop,
  output logic       mem_we,
  output mem_addr_t  mem_adr,
  output word_t      mem_dat,
  output logic       wr_done
);

  mem_addr_t dest_q;
  word_cnt_t last_q;  // index of the final word
  logic      last_wr;

  // write and pop together, no extra latency
  assign pop     = !empty && mem_ready;
  assign mem_we  = pop;
  assign mem_adr = dest_q + mem_addr_t'(head.idx);
  assign mem_dat = head.data;
  assign last_wr = pop && (head.idx == last_q);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dest_q  <= '0;
      last_q  <= '0;
      wr_done <= 1'b0;
    end else begin
      if (start) begin
        dest_q <= dest_base;
        last_q <= boot_words - word_cnt_t'(1);
      end
      wr_done <= last_wr;
    end
  end

endmodule

/* rtl/word_fifo.sv */
////////////////////
// small synchronous FIFO between flash reads and memory writes
// head is valid whenever empty is low, push and pop may share a cycle
////////////////////

`timescale 1ns/10ps

module word_fifo import flash_boot_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  boot_word_t push_word,
  input  logic       pop,
  output boot_word_t head,
  output logic       empty,
  output logic       full
);

  boot_word_t mem [FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  fifo_cnt_t  count;

  assign empty = (count == '0);
  assign full  = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign head  = mem[rd_ptr];

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  ////////////////////
  // pointers and fill level
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* src.f */
rtl/flash_boot_pkg.sv
rtl/flash_read_ctrl.sv
rtl/boot_fetch.sv
rtl/word_fifo.sv
rtl/mem_writer.sv
rtl/flash_boot_top.sv
tb/flash_model.sv
tb/flash_boot_sva.sv
tb/tb_flash_boot.sv

/* tb/flash_boot_sva.sv */
////////////////////
// protocol checks for the boot copy engine
// bound into every flash_boot_top instance
////////////////////

`timescale 1ns/10ps

module flash_boot_sva import flash_boot_pkg::*; (
  input logic     clk,
  input logic     rst,
  input fl_pins_t fl_pins,
  input logic     mem_we,
  input logic     mem_ready,
  input logic     done,
  input logic     push,
  input logic     full
);

  int fail_count = 0;  // read by the testbench

  // part selected and in read mode from the first clock after reset
  read_mode_a: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (!fl_pins.ce_n && !fl_pins.oe_n && fl_pins.rst_n))
    else begin
      fail_count++;
      $error("flash left read mode after reset");
    end

  mem_we_a: assert property (@(posedge clk) disable iff (rst) mem_we |-> mem_ready)
    else begin
      fail_count++;
      $error("memory write while mem_ready low");
    end

  done_pulse_a: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_count++;
      $error("done longer than one cycle");
    end

  no_overflow_a: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else begin
      fail_count++;
      $error("push into a full FIFO");
    end

endmodule

bind flash_boot_top flash_boot_sva sva_i (
  .clk       (clk),
  .rst       (rst),
  .fl_pins   (fl_pins),
  .mem_we    (mem_we),
  .mem_ready (mem_ready),
  .done      (done),
  .push      (push),
  .full      (full)
);

/* tb/flash_model.sv */
////////////////////
// behavioural byte-wide NOR flash, read path only
// the testbench fills the contents array, data follows the address after 60 ns
// and floats to X while the part is deselected or its outputs are off
////////////////////

`timescale 1ns/10ps

module flash_model import flash_boot_pkg::*; (
  input  fl_pins_t fl_pins,
  output fl_data_t fl_dat_r
);

  fl_data_t contents [16384];  // low 14 address bits decoded

  // 70 ns class part, 60 ns typical access
  assign #60 fl_dat_r = (fl_pins.ce_n || fl_pins.oe_n) ? {FL_DW{1'bx}}
                                                        : contents[fl_pins.adr[13:0]];

endmodule

/* tb/tb_flash_boot.sv */
////////////////////
// testbench for the boot copy engine
// fills the flash model from an LCG, runs four copies (one with random
// memory stalls) and checks every write against the expected flash word
////////////////////

`timescale 1ns/10ps

module tb_flash_boot import flash_boot_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      start;
  word_cnt_t boot_base;
  word_cnt_t boot_words;
  mem_addr_t dest_base;
  fl_pins_t  fl_pins;
  fl_data_t  fl_dat_r;
  logic      mem_ready;
  logic      mem_we;
  mem_addr_t mem_adr;
  word_t     mem_dat;
  logic      busy;
  logic      done;

  fl_data_t    flash_img [16384];  // copy of the flash contents
  word_t       sink_mem [65536];   // memory sink
  int unsigned lcg_state = 49;
  int          errors = 0;
  int          total_writes = 0;
  int          wr_count = 0;
  int          done_count = 0;
  int          exp_base = 0;
  mem_addr_t   exp_dest = '0;
  bit          copy_active = 1'b0;
  bit          stall_on = 1'b0;
  int          stall_cycles = 0;
  int          run_left = 0;
  int          cycles = 0;
  int          cycle_limit = (1 + 16 + 20 + 12) * 20 + 200;  // words of all copies

  flash_boot_top dut_i (.*);

  flash_model flash_i (.fl_pins(fl_pins), .fl_dat_r(fl_dat_r));

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  // four flash bytes of a word, first byte in the top lane
  function automatic word_t ref_word(int idx);
    return {flash_img[idx*4], flash_img[idx*4+1], flash_img[idx*4+2], flash_img[idx*4+3]};
  endfunction

  task automatic log_error(string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // compare and sink
  ////////////////////

  always @(posedge clk) begin : compare
    if (!rst && mem_we) begin
      assert (copy_active && mem_ready)
        else log_error($sformatf("write to %h outside a copy or while stalled", mem_adr));
      assert (mem_adr === exp_dest + mem_addr_t'(wr_count))
        else log_error($sformatf("write to %h, expected %h", mem_adr,
                                 exp_dest + mem_addr_t'(wr_count)));
      assert (mem_dat === ref_word(exp_base + wr_count))
        else log_error($sformatf("data %h at %h, expected %h", mem_dat, mem_adr,
                                 ref_word(exp_base + wr_count)));
      sink_mem[mem_adr] = mem_dat;
      wr_count++;
      total_writes++;
    end
    if (!rst && done) done_count++;
  end

  // random mem_ready runs, long lows so the FIFO fills
  always @(posedge clk) begin : stall_gen
    if (!mem_ready) stall_cycles++;
    if (!stall_on || stall_cycles > 2000) begin
      run_left = 0;
      #2 mem_ready = 1'b1;
    end else if (run_left > 0) begin
      run_left--;
    end else begin
      #2 mem_ready = !mem_ready;
      run_left = mem_ready ? lcg_next() % 8 : lcg_next() % 128;
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles > cycle_limit + stall_cycles) begin
      $display("timeout: copy still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic run_copy(int base, int words, mem_addr_t dest, bit stalls);
    @(posedge clk);
    #2;
    exp_base    = base;
    exp_dest    = dest;
    wr_count    = 0;
    done_count  = 0;
    copy_active = 1'b1;
    stall_on    = stalls;
    start       = 1'b1;
    boot_base   = word_cnt_t'(base);
    boot_words  = word_cnt_t'(words);
    dest_base   = dest;
    @(posedge clk);
    #2 start = 1'b0;
    @(negedge clk);
    assert (busy) else log_error("busy not raised after start");
    while (done_count == 0) @(negedge clk);
    stall_on = 1'b0;
    assert (wr_count == words)
      else log_error($sformatf("done after %0d writes, expected %0d", wr_count, words));
    @(negedge clk);
    assert (!busy) else log_error("busy still high after done");
    repeat (4) @(negedge clk);
    assert (done_count == 1)
      else log_error($sformatf("%0d done pulses for one copy", done_count));
    copy_active = 1'b0;
    for (int k = 0; k < words; k++) begin
      assert (sink_mem[dest + mem_addr_t'(k)] === ref_word(base + k))
        else log_error($sformatf("memory word %h wrong after copy", dest + mem_addr_t'(k)));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    rst        = 1'b1;
    start      = 1'b0;
    boot_base  = '0;
    boot_words = '0;
    dest_base  = '0;
    mem_ready  = 1'b1;
    for (int a = 0; a < 16384; a++) begin
      flash_img[a]        = fl_data_t'(lcg_next());
      flash_i.contents[a] = flash_img[a];
    end
    repeat (8) begin
      @(posedge clk);
      #2;
      assert (!busy && !done && !mem_we && !fl_pins.rst_n && fl_pins.ce_n && fl_pins.oe_n)
        else log_error("outputs not in reset state during reset");
    end
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    assert (!busy && !done && !mem_we && fl_pins.rst_n && !fl_pins.ce_n && !fl_pins.oe_n)
      else log_error("flash not in read mode or outputs active after reset");

    run_copy(5, 1, 16'h0040, 1'b0);
    run_copy(100, 16, 16'h0100, 1'b0);
    run_copy(300, 20, 16'h0200, 1'b1);     // back-pressure
    run_copy(2000, 12, 16'h1000, 1'b0);    // restart on a new region

    $display("summary: %0d writes checked, %0d errors, %0d assertion failures",
             total_writes, errors, dut_i.sva_i.fail_count);
    if (errors == 0 && dut_i.sva_i.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
